//--- Makefile
VERILATOR ?= verilator
TOP       ?= eeprom_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/eeprom_assertions.sv
module eeprom_assertions (
    input logic CLK,
    input logic RESET,
    input logic ack,
    input logic busy,
    input logic err,
    input logic scl,
    input logic sda_low,
    input logic sda_in
);

    logic failed = 1'b0;  // read by the testbench

    assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
    else
    begin
        failed = 1'b1;
        $error("ack high for more than one cycle");
    end

    assert property (@(posedge CLK) disable iff (RESET) ack == $fell(busy))
    else
    begin
        failed = 1'b1;
        $error("busy did not fall together with ack");
    end

    // start and stop are the only SDA edges under high SCL
    assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && sda_in != $past(sda_in)) |-> busy)
    else
    begin
        failed = 1'b1;
        $error("SDA changed while SCL high and the master idle");
    end

    // also covers the first cycles after reset
    assert property (@(posedge CLK) disable iff (RESET) !busy |-> scl && !sda_low)
    else
    begin
        failed = 1'b1;
        $error("bus not idle while the master is not busy");
    end

    assert property (@(posedge CLK) disable iff (RESET) err |-> ack)
    else
    begin
        failed = 1'b1;
        $error("err high outside the ack cycle");
    end

endmodule

bind eeprom_top eeprom_assertions u_assertions (.*);

//--- bench/eeprom_model.sv
module eeprom_model (
    input  logic CLK,
    input  logic scl,
    input  logic sda,      // bus level
    input  logic silent,   // acknowledge nothing
    output logic sda_low
);
    import eeprom_pkg::*;

    logic [DATA_W-1:0] mem [0:2**ADDR_W-1];
    logic [ADDR_W-1:0] ptr;
    logic [DATA_W-1:0] sh;
    logic [3:0]        nbit;           // 0..7 data, 8 byte in, 9 ack slot
    logic [1:0]        nbyte;
    logic              rw;
    logic              drive = 1'b0;
    logic              scl_d = 1'b1;
    logic              sda_d = 1'b1;
    logic              active = 1'b0;
    logic              sending = 1'b0; // slave shifts read data out

    assign sda_low = drive;

    initial
    begin
        for (int i = 0; i < 2**ADDR_W; i++)
            mem[i] <= DATA_W'(i) ^ 8'h5a;
    end

    always @(posedge CLK)
    begin
        scl_d <= scl;
        sda_d <= sda;
        if (scl && scl_d && sda_d && !sda)
        begin
            active  <= 1'b1;  // start or repeated start
            sending <= 1'b0;
            nbit    <= '0;
            nbyte   <= '0;
        end
        else if (scl && scl_d && !sda_d && sda)
            active <= 1'b0;   // stop
        else if (active && scl && !scl_d && !sending && nbit < 8)
        begin
            sh   <= {sh[DATA_W-2:0], sda};
            nbit <= nbit + 1'b1;
        end
        else if (active && !scl && scl_d)
        begin
            if (sending)
            begin
                drive <= (nbit < 8) && !sh[DATA_W-2];
                sh    <= sh << 1;
                nbit  <= nbit + 1'b1;
                if (nbit == 8)
                    active <= 1'b0;  // master nack and stop follow
            end
            else if (nbit == 8)
            begin
                if (!silent && (nbyte != 0 || sh[7:4] == DEVICE_CODE))
                    drive <= 1'b1;
                else
                    active <= 1'b0;
                if (nbyte == 0)
                begin
                    ptr[ADDR_W-1:DATA_W] <= sh[3:1];  // page bits
                    rw                   <= sh[0];
                end
                else if (nbyte == 1)
                    ptr[DATA_W-1:0] <= sh;
                else
                    mem[ptr] <= sh;
                nbit <= 4'd9;
            end
            else if (nbit == 9)
            begin
                drive <= 1'b0;
                nbit  <= '0;
                nbyte <= nbyte + 1'b1;
                if (nbyte == 0 && rw)
                begin
                    sending <= 1'b1;
                    sh      <= mem[ptr];
                    drive   <= !mem[ptr][DATA_W-1];
                    nbit    <= 4'd1;
                end
            end
        end
    end

endmodule

//--- bench/eeprom_tb.sv
module eeprom_tb;
    import eeprom_pkg::*;

    localparam int MAX_CYCLES = 20000;  // about 50 transfers of at most ~330 cycles

    logic              CLK = 1'b0;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wr_data;
    logic [DATA_W-1:0] rd_data;
    logic              ack;
    logic              busy;
    logic              err;
    logic              scl;
    logic              dut_sda_low;
    logic              model_sda_low;
    logic              sda;
    logic              silent;
    logic [DATA_W-1:0] shadow [0:2**ADDR_W-1];
    logic              written [0:2**ADDR_W-1];
    logic [ADDR_W-1:0] addr_list [0:19];
    integer            seed = 32'hca7f_f8ec;
    int                cycles = 0;

    assign sda = !(dut_sda_low || model_sda_low);  // open drain, pulled up

    eeprom_top #(
        .SCL_HALF (4)
    ) DUT (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .sda_in  (sda),
        .rd_data (rd_data),
        .ack     (ack),
        .busy    (busy),
        .err     (err),
        .scl     (scl),
        .sda_low (dut_sda_low)
    );

    eeprom_model u_model (
        .CLK     (CLK),
        .scl     (scl),
        .sda     (sda),
        .silent  (silent),
        .sda_low (model_sda_low)
    );

    always #10 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES)
        begin
            $display("timed out after %0d cycles without finishing", MAX_CYCLES);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    always @(negedge CLK)
    begin
        if (DUT.u_assertions.failed)
        begin
            $display("a protocol assertion on the DUT failed");
            $display("Test failed");
            $fatal(1, "assertion failure");
        end
    end

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "value mismatch");
    endtask

    // one host request, returns in the ack cycle
    task automatic transfer(input logic is_write, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d, output logic [DATA_W-1:0] q,
                            output logic e);
        @(negedge CLK);
        wr      = is_write;
        rd      = !is_write;
        addr    = a;
        wr_data = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        while (!ack)
            @(negedge CLK);
        q = rd_data;
        e = err;
    endtask

    task automatic write_byte(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        logic [DATA_W-1:0] q;
        logic              e;
        transfer(1'b1, a, d, q, e);
        if (e !== silent)
            report_mismatch($sformatf("write to %h gave err %b, expected %b", a, e, silent));
        if (!silent)
        begin
            shadow[a]  = d;
            written[a] = 1'b1;
        end
    endtask

    task automatic read_check(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] expected);
        logic [DATA_W-1:0] q;
        logic              e;
        transfer(1'b0, a, '0, q, e);
        if (e !== 1'b0)
            report_mismatch($sformatf("read of %h gave err %b, expected 0", a, e));
        if (q !== expected)
            report_mismatch($sformatf("read of %h returned %h, expected %h", a, q, expected));
    endtask

    initial
    begin
        logic [ADDR_W-1:0] a;
        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wr_data = '0;
        silent  = 1'b0;
        for (int i = 0; i < 2**ADDR_W; i++)
        begin
            shadow[i]  = DATA_W'(i) ^ 8'h5a;  // erased pattern of the model
            written[i] = 1'b0;
        end
        repeat (2) @(negedge CLK);
        RESET = 1'b0;

        // high address bits travel in the control byte
        write_byte(11'h7a5, 8'h3c);
        write_byte(11'h312, 8'hc1);
        read_check(11'h7a5, 8'h3c);
        read_check(11'h312, 8'hc1);

        for (int i = 0; i < 20; i++)
        begin
            addr_list[i] = (i == 19) ? addr_list[4] : ADDR_W'($random(seed));
            write_byte(addr_list[i], DATA_W'($random(seed)));
        end
        for (int i = 0; i < 20; i++)
            read_check(addr_list[i], shadow[addr_list[i]]);

        a = 11'h6c3;
        while (written[a])
            a = a + 1'b1;
        read_check(a, a[7:0] ^ 8'h5a);

        // no slave answers, location must keep its value
        silent = 1'b1;
        write_byte(11'h312, 8'h00);
        silent = 1'b0;
        read_check(11'h312, shadow[11'h312]);

        @(negedge CLK);
        wr      = 1'b1;
        addr    = 11'h4e1;
        wr_data = 8'h96;
        @(negedge CLK);
        wr = 1'b0;
        repeat (10) @(negedge CLK);
        wr      = 1'b1;  // lands while busy
        wr_data = 8'h69;
        @(negedge CLK);
        wr = 1'b0;
        while (!ack)
            @(negedge CLK);
        read_check(11'h4e1, 8'h96);

        repeat (20) @(negedge CLK);
        if (DUT.u_assertions.failed)
        begin
            $display("a protocol assertion on the DUT failed");
            $display("Test failed");
            $fatal(1, "assertion failure");
        end
        else
        begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

//--- common/bit_link_if.sv
interface bit_link_if;
    import eeprom_pkg::*;

    bit_cmd_e            cmd;
    logic                go;       // one cycle, only when nothing outstanding
    logic [DATA_W-1:0]   tx_byte;
    logic [DATA_W-1:0]   rx_byte;  // valid with done
    logic                done;
    logic                nack;     // valid with done after BC_WRITE

    modport seq (
        output cmd,
        output go,
        output tx_byte,
        input  rx_byte,
        input  done,
        input  nack
    );

    modport engine (
        input  cmd,
        input  go,
        input  tx_byte,
        output rx_byte,
        output done,
        output nack
    );

endinterface

//--- common/eeprom_pkg.sv
package eeprom_pkg;

    localparam int ADDR_W = 11;  // 2K bytes
    localparam int DATA_W = 8;

    // fixed prefix of every control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // commands from the sequencer to the bit engine
    typedef enum logic [1:0] {
        BC_START,  // also used as repeated start
        BC_STOP,
        BC_WRITE,  // 8 bits out, slave ack in
        BC_READ    // 8 bits in, master nack out
    } bit_cmd_e;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA,
        S_RSTART,
        S_CTRL_R,
        S_READ,
        S_STOP,
        S_DONE
    } seq_state_e;

endpackage

//--- eeprom_master/eeprom_bit_engine.sv
module eeprom_bit_engine #(
    parameter int SCL_HALF = 4
) (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       sda_in,
    output logic       scl,
    output logic       sda_low,
    bit_link_if.engine link
);
    import eeprom_pkg::*;

    localparam int             CNT_W    = $clog2(SCL_HALF);
    localparam logic [CNT_W-1:0] CNT_MID  = CNT_W'(SCL_HALF / 2 - 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCL_HALF - 1);

    logic              active;
    bit_cmd_e          cmd_q;
    logic [CNT_W-1:0]  cnt;       // cycle within a half period
    logic [4:0]        half;      // half period within the command
    logic [DATA_W-1:0] sh;
    logic              done_q;
    logic              nack_q;
    logic              at_mid;
    logic              at_last;
    logic              is_byte;
    logic              last_half;
    logic              high_half;
    logic              data_bit;  // low for the ack slot

    assign at_mid    = active && (cnt == CNT_MID);
    assign at_last   = active && (cnt == CNT_LAST);
    assign is_byte   = (cmd_q == BC_WRITE) || (cmd_q == BC_READ);
    assign last_half = is_byte ? (half == 5'd17) : (half == 5'd1);
    assign high_half = half[0];
    assign data_bit  = (half[4:1] != 4'd8);

    assign link.done    = done_q;
    assign link.rx_byte = sh;
    assign link.nack    = nack_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            cnt     <= '0;
            half    <= '0;
            scl     <= 1'b1;   // bus idle
            sda_low <= 1'b0;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (!active)
            begin
                if (link.go)
                begin
                    active <= 1'b1;
                    cnt    <= '0;
                    half   <= '0;
                    if (link.cmd == BC_START)
                        sda_low <= 1'b0;  // SDA high before SCL rises
                    else if (link.cmd == BC_STOP)
                        sda_low <= 1'b1;  // SDA low while SCL still low
                end
            end
            else
            begin
                cnt <= at_last ? '0 : cnt + 1'b1;
                if (at_last)
                    half <= half + 5'd1;

                if (is_byte)
                begin
                    // bit data set mid low half
                    if (at_mid && !high_half)
                        sda_low <= (cmd_q == BC_WRITE) && data_bit && !sh[DATA_W-1];
                    if (at_last)
                        scl <= !high_half;
                end
                else
                begin
                    if (at_mid && !high_half)
                        scl <= 1'b1;
                    if (at_mid && high_half)
                        sda_low <= (cmd_q == BC_START);  // the condition itself
                    if (at_last && high_half && cmd_q == BC_START)
                        scl <= 1'b0;
                end

                if (at_last && last_half)
                begin
                    active <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // shift register and ack sample
    always_ff @(posedge CLK)
    begin
        if (!active && link.go)
        begin
            cmd_q <= link.cmd;
            sh    <= link.tx_byte;
        end
        else if (at_mid && data_bit)
        begin
            if (cmd_q == BC_WRITE && !high_half)
                sh <= {sh[DATA_W-2:0], 1'b0};
            if (cmd_q == BC_READ && high_half)
                sh <= {sh[DATA_W-2:0], sda_in};  // MSB first
        end
        if (at_mid && high_half && !data_bit && cmd_q == BC_WRITE)
            nack_q <= sda_in;
    end

endmodule

//--- eeprom_master/eeprom_seq.sv
module eeprom_seq (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wr_data,
    output logic [eeprom_pkg::DATA_W-1:0] rd_data,
    output logic                          ack,
    output logic                          busy,
    output logic                          err,
    bit_link_if.seq                       link
);
    import eeprom_pkg::*;

    seq_state_e        state;
    seq_state_e        next_state;
    logic              pending;     // a bit command is outstanding
    logic              err_q;
    logic              is_read;
    logic              cmd_state;
    logic              accept;
    logic              write_nack;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] data_q;
    logic [2:0]        page;        // high address bits, go into control byte

    assign page = addr_q[ADDR_W-1:ADDR_W-3];

    assign busy   = (state != S_IDLE) && (state != S_DONE);
    assign ack    = (state == S_DONE);
    assign err    = ack && err_q;
    assign accept = !busy && (wr || rd);

    // one bit command per state
    always_comb
    begin
        cmd_state    = 1'b1;
        link.cmd     = BC_START;
        link.tx_byte = '0;
        case (state)
            S_START, S_RSTART:
                link.cmd = BC_START;
            S_CTRL_W:
            begin
                link.cmd     = BC_WRITE;
                link.tx_byte = {DEVICE_CODE, page, 1'b0};
            end
            S_ADDR:
            begin
                link.cmd     = BC_WRITE;
                link.tx_byte = addr_q[DATA_W-1:0];
            end
            S_DATA:
            begin
                link.cmd     = BC_WRITE;
                link.tx_byte = data_q;
            end
            S_CTRL_R:
            begin
                link.cmd     = BC_WRITE;
                link.tx_byte = {DEVICE_CODE, page, 1'b1};
            end
            S_READ:
                link.cmd = BC_READ;
            S_STOP:
                link.cmd = BC_STOP;
            default:
                cmd_state = 1'b0;  // idle and done issue nothing
        endcase
    end

    assign link.go    = cmd_state && !pending;
    assign write_nack = (link.cmd == BC_WRITE) && link.nack;

    always_comb
    begin
        case (state)
            S_START:  next_state = S_CTRL_W;
            S_CTRL_W: next_state = S_ADDR;
            S_ADDR:   next_state = is_read ? S_RSTART : S_DATA;
            S_DATA:   next_state = S_STOP;
            S_RSTART: next_state = S_CTRL_R;
            S_CTRL_R: next_state = S_READ;
            S_READ:   next_state = S_STOP;
            S_STOP:   next_state = S_DONE;
            default:  next_state = S_IDLE;
        endcase
        if (write_nack)
            next_state = S_STOP;  // no slave, close the bus
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= S_IDLE;
            pending <= 1'b0;
            err_q   <= 1'b0;
        end
        else
        begin
            if (link.go)
                pending <= 1'b1;
            case (state)
                S_IDLE, S_DONE:
                begin
                    if (accept)
                    begin
                        state <= S_START;
                        err_q <= 1'b0;
                    end
                    else
                        state <= S_IDLE;
                end
                default:
                begin
                    if (link.done)
                    begin
                        pending <= 1'b0;
                        state   <= next_state;
                        if (write_nack)
                            err_q <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_q  <= addr;
            data_q  <= wr_data;
            is_read <= !wr;  // wr wins over rd
        end
        if (state == S_READ && link.done)
            rd_data <= link.rx_byte;
    end

endmodule

//--- filelist.f
common/eeprom_pkg.sv
common/bit_link_if.sv
eeprom_master/eeprom_bit_engine.sv
eeprom_master/eeprom_seq.sv
hdl/eeprom_top.sv
bench/eeprom_model.sv
bench/eeprom_assertions.sv
bench/eeprom_tb.sv

//--- hdl/eeprom_top.sv
module eeprom_top #(
    parameter int SCL_HALF = 4
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wr_data,
    input  logic                          sda_in,
    output logic [eeprom_pkg::DATA_W-1:0] rd_data,
    output logic                          ack,
    output logic                          busy,
    output logic                          err,
    output logic                          scl,
    output logic                          sda_low
);

    bit_link_if link ();

    eeprom_seq u_seq (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .busy    (busy),
        .err     (err),
        .link    (link.seq)
    );

    // serial side, open drain on SDA
    eeprom_bit_engine #(
        .SCL_HALF (SCL_HALF)
    ) u_engine (
        .CLK     (CLK),
        .RESET   (RESET),
        .sda_in  (sda_in),
        .scl     (scl),
        .sda_low (sda_low),
        .link    (link.engine)
    );

endmodule
